// ==== pm_argmax_tree.sv ====
module pm_argmax_tree
    import pm_metric_pkg::*;
#(
    // Power of two, at least 2
    parameter int LEAVES = 8
) (
    input  metric_t [LEAVES-1:0]        metrics_i,
    output metric_t                     max_o,
    output logic [$clog2(LEAVES)-1:0]   idx_o
);

    localparam int LEVELS = $clog2(LEAVES);
    localparam int IDX_W  = LEVELS;

    // Level 0 holds the leaves, level LEVELS the single winner
    metric_t          lvl_val [LEVELS+1][LEAVES];
    logic [IDX_W-1:0] lvl_idx [LEVELS+1][LEAVES];

    //--------------------------------------------------------------------------
    // Leaves
    //--------------------------------------------------------------------------

    for (genvar n = 0; n < LEAVES; n++) begin : g_leaf
        assign lvl_val[0][n] = metrics_i[n];
        assign lvl_idx[0][n] = IDX_W'(n);
    end

    //--------------------------------------------------------------------------
    // Compare levels
    //--------------------------------------------------------------------------

    for (genvar l = 0; l < LEVELS; l++) begin : g_level
        for (genvar n = 0; n < (LEAVES >> (l + 1)); n++) begin : g_node
            logic take_lo;

            // Greater or equal, so on a tie the lower index survives
            assign take_lo = lvl_val[l][2*n] >= lvl_val[l][2*n+1];

            assign lvl_val[l+1][n] = take_lo ? lvl_val[l][2*n] : lvl_val[l][2*n+1];
            assign lvl_idx[l+1][n] = take_lo ? lvl_idx[l][2*n] : lvl_idx[l][2*n+1];
        end
    end

    assign max_o = lvl_val[LEVELS][0];
    assign idx_o = lvl_idx[LEVELS][0];

endmodule

// ==== pm_max_search.sv ====
module pm_max_search
    import pm_trellis_pkg::*;
    import pm_metric_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      rst_an_i,
    input  logic                      clear_i,
    input  logic                      valid_i,
    input  search_mode_t              mode_i,
    input  metric_t [NUM_STATES-1:0]  pm_i,
    output logic                      s1_valid_o,
    output search_mode_t              s1_mode_o,
    output metric_t [NUM_STATES-1:0]  s1_pm_o,
    output metric_t                   s1_max_o,
    output state_idx_t                s1_idx_o
);

    localparam int LOCAL_IDX_W = $clog2(GROUP_SIZE);
    localparam int GROUP_IDX_W = $clog2(NUM_GROUPS);

    metric_t [NUM_GROUPS-1:0]  grp_max;
    metric_t [NUM_GROUPS-1:0]  grp_max_masked;
    logic [LOCAL_IDX_W-1:0]    grp_idx [NUM_GROUPS];
    metric_t                   top_max;
    logic [GROUP_IDX_W-1:0]    top_grp;
    state_idx_t                win_idx;

    //--------------------------------------------------------------------------
    // First level with one tree per group of states
    //--------------------------------------------------------------------------

    for (genvar g = 0; g < NUM_GROUPS; g++) begin : g_group
        pm_argmax_tree #(
            .LEAVES (GROUP_SIZE)
        ) u_grp_tree (
            .metrics_i (pm_i[g*GROUP_SIZE +: GROUP_SIZE]),
            .max_o     (grp_max[g]),
            .idx_o     (grp_idx[g])
        );
    end

    // Groups above the active range drop to the floor value
    always_comb begin
        for (int g = 0; g < NUM_GROUPS; g++) begin
            if (g * GROUP_SIZE < active_states(mode_i)) begin
                grp_max_masked[g] = grp_max[g];
            end else begin
                grp_max_masked[g] = METRIC_MIN;
            end
        end
    end

    //--------------------------------------------------------------------------
    // Second level across group winners
    //--------------------------------------------------------------------------

    // Group 0 is always active and ties go low, so a masked group never wins
    pm_argmax_tree #(
        .LEAVES (NUM_GROUPS)
    ) u_top_tree (
        .metrics_i (grp_max_masked),
        .max_o     (top_max),
        .idx_o     (top_grp)
    );

    // Local index taken from the same group as the winning metric
    assign win_idx = {top_grp, grp_idx[top_grp]};

    //--------------------------------------------------------------------------
    // Stage register
    //--------------------------------------------------------------------------

    always_ff @(posedge clk_i or negedge rst_an_i) begin
        if (!rst_an_i) begin
            s1_valid_o <= 1'b0;
        end else if (clear_i) begin
            s1_valid_o <= 1'b0;
        end else begin
            s1_valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            s1_mode_o <= mode_i;
            s1_pm_o   <= pm_i;
            s1_max_o  <= top_max;
            s1_idx_o  <= win_idx;
        end
    end

endmodule

// ==== pm_metric_pkg.sv ====
package pm_metric_pkg;

    localparam int METRIC_W = 8;

    // Signed path metric where larger is better
    typedef logic signed [METRIC_W-1:0] metric_t;

    typedef logic [pm_trellis_pkg::STATE_IDX_W-1:0] state_idx_t;

    // Saturation bounds
    localparam metric_t METRIC_MAX = {1'b0, {(METRIC_W - 1){1'b1}}};
    localparam metric_t METRIC_MIN = {1'b1, {(METRIC_W - 1){1'b0}}};

    // Metric minus maximum taken one bit wider and clamped back to metric range
    function automatic metric_t sat_diff(metric_t pm, metric_t max);
        logic signed [METRIC_W:0] diff;

        diff = (METRIC_W + 1)'(pm) - (METRIC_W + 1)'(max);
        if (diff > METRIC_MAX) begin
            return METRIC_MAX;
        end else if (diff < METRIC_MIN) begin
            return METRIC_MIN;
        end else begin
            return metric_t'(diff);
        end
    endfunction

    // With max the true maximum the upper clamp never fires,
    // only the lower one does

endpackage

// ==== pm_norm_assertions.sv ====
module pm_norm_assertions
    import pm_trellis_pkg::*;
    import pm_metric_pkg::*;
(
    input logic                      clk_i,
    input logic                      rst_an_i,
    input logic                      clear_i,
    input logic                      valid_i,
    input search_mode_t              mode_i,
    input logic                      valid_o,
    input metric_t [NUM_STATES-1:0]  pm_nom_o,
    input state_idx_t                max_idx_o
);

    int unsigned error_count = 0;

    // Two-stage latency unless a clear hits either stage
    a_latency: assert property (@(posedge clk_i) disable iff (!rst_an_i)
        (!$past(clear_i, 1) && !$past(clear_i, 2)) |-> (valid_o == $past(valid_i, 2)))
    else begin
        $error("valid_o does not follow valid_i by two cycles");
        error_count++;
    end

    a_winner_zero: assert property (@(posedge clk_i) disable iff (!rst_an_i)
        valid_o |-> (pm_nom_o[max_idx_o] == '0))
    else begin
        $error("winning state's normalized metric is not zero");
        error_count++;
    end

    // Mode of the item is the one seen two edges back
    a_idx_range: assert property (@(posedge clk_i) disable iff (!rst_an_i)
        valid_o |-> (int'(max_idx_o) < active_states($past(mode_i, 2))))
    else begin
        $error("max_idx_o outside the active states of the mode");
        error_count++;
    end

endmodule

// ==== pm_norm_top.sv ====
module pm_norm_top
    import pm_trellis_pkg::*;
    import pm_metric_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      rst_an_i,
    input  logic                      clear_i,
    input  logic                      valid_i,
    input  search_mode_t              mode_i,
    input  metric_t [NUM_STATES-1:0]  pm_i,
    output logic                      valid_o,
    output metric_t [NUM_STATES-1:0]  pm_nom_o,
    output state_idx_t                max_idx_o
);

    // Search to normalize stage
    logic                      s1_valid;
    search_mode_t              s1_mode;
    metric_t [NUM_STATES-1:0]  s1_pm;
    metric_t                   s1_max;
    state_idx_t                s1_idx;

    //--------------------------------------------------------------------------
    // Stage one finds the maximum
    //--------------------------------------------------------------------------

    pm_max_search u_max_search (
        .clk_i      (clk_i),
        .rst_an_i   (rst_an_i),
        .clear_i    (clear_i),
        .valid_i    (valid_i),
        .mode_i     (mode_i),
        .pm_i       (pm_i),
        .s1_valid_o (s1_valid),
        .s1_mode_o  (s1_mode),
        .s1_pm_o    (s1_pm),
        .s1_max_o   (s1_max),
        .s1_idx_o   (s1_idx)
    );

    //--------------------------------------------------------------------------
    // Stage two normalizes the metrics
    //--------------------------------------------------------------------------

    pm_normalize_stage u_normalize (
        .clk_i      (clk_i),
        .rst_an_i   (rst_an_i),
        .clear_i    (clear_i),
        .s1_valid_i (s1_valid),
        .s1_mode_i  (s1_mode),
        .s1_pm_i    (s1_pm),
        .s1_max_i   (s1_max),
        .s1_idx_i   (s1_idx),
        .valid_o    (valid_o),
        .pm_nom_o   (pm_nom_o),
        .max_idx_o  (max_idx_o)
    );

endmodule

// ==== pm_normalize_stage.sv ====
module pm_normalize_stage
    import pm_trellis_pkg::*;
    import pm_metric_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      rst_an_i,
    input  logic                      clear_i,
    input  logic                      s1_valid_i,
    input  search_mode_t              s1_mode_i,
    input  metric_t [NUM_STATES-1:0]  s1_pm_i,
    input  metric_t                   s1_max_i,
    input  state_idx_t                s1_idx_i,
    output logic                      valid_o,
    output metric_t [NUM_STATES-1:0]  pm_nom_o,
    output state_idx_t                max_idx_o
);

    logic [NUM_STATES-1:0]     upd_en;
    metric_t [NUM_STATES-1:0]  pm_sat;

    //--------------------------------------------------------------------------
    // Update enables and saturated differences
    //--------------------------------------------------------------------------

    always_comb begin
        for (int n = 0; n < NUM_STATES; n++) begin
            // Only low states of a valid item move
            upd_en[n] = s1_valid_i && (n < active_states(s1_mode_i));
            pm_sat[n] = sat_diff(s1_pm_i[n], s1_max_i);
        end
    end

    //--------------------------------------------------------------------------
    // Output registers
    //--------------------------------------------------------------------------

    always_ff @(posedge clk_i or negedge rst_an_i) begin
        if (!rst_an_i) begin
            valid_o <= 1'b0;
        end else if (clear_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= s1_valid_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_an_i) begin
        if (!rst_an_i) begin
            max_idx_o <= '0;
        end else if (clear_i) begin
            max_idx_o <= '0;
        end else if (s1_valid_i) begin
            max_idx_o <= s1_idx_i;
        end
    end

    // Inactive states hold their last normalized value
    always_ff @(posedge clk_i or negedge rst_an_i) begin
        if (!rst_an_i) begin
            pm_nom_o <= '0;
        end else if (clear_i) begin
            pm_nom_o <= '0;
        end else begin
            for (int n = 0; n < NUM_STATES; n++) begin
                if (upd_en[n]) begin
                    pm_nom_o[n] <= pm_sat[n];
                end
            end
        end
    end

endmodule

// ==== pm_trellis_pkg.sv ====
package pm_trellis_pkg;

    //--------------------------------------------------------------------------
    // Trellis geometry
    //--------------------------------------------------------------------------

    localparam int NUM_STATES  = 64;
    localparam int GROUP_SIZE  = 8;
    localparam int NUM_GROUPS  = NUM_STATES / GROUP_SIZE;
    localparam int STATE_IDX_W = $clog2(NUM_STATES);

    //--------------------------------------------------------------------------
    // Search mode
    //--------------------------------------------------------------------------

    // Larger codes search fewer states
    typedef enum logic [1:0] {
        ALL_64 = 2'd0,
        LOW_32 = 2'd1,
        LOW_16 = 2'd2,
        LOW_8  = 2'd3
    } search_mode_t;

    // Number of low states that take part in the search
    function automatic int active_states(search_mode_t mode);
        case (mode)
            ALL_64: begin
                return NUM_STATES;
            end
            LOW_32: begin
                return NUM_STATES / 2;
            end
            LOW_16: begin
                return NUM_STATES / 4;
            end
            default: begin
                return NUM_STATES / 8;
            end
        endcase
    endfunction

endpackage

// ==== project.f ====
+incdir+.
pm_trellis_pkg.sv
pm_metric_pkg.sv
pm_argmax_tree.sv
pm_max_search.sv
pm_normalize_stage.sv
pm_norm_top.sv
pm_norm_assertions.sv
tb_pm_norm.sv

// ==== tb_pm_norm_model.svh ====
`ifndef TB_PM_NORM_MODEL_SVH
`define TB_PM_NORM_MODEL_SVH

// Low states searched for each mode
function automatic int mode_count(search_mode_t mode);
    case (mode)
        ALL_64:  return 64;
        LOW_32:  return 32;
        LOW_16:  return 16;
        default: return 8;
    endcase
endfunction

// Clamp to the signed 8-bit range
function automatic metric_t clamp_metric(int value);
    if (value > 127) begin
        return metric_t'(127);
    end else if (value < -128) begin
        return metric_t'(-128);
    end
    return metric_t'(value);
endfunction

// Strictly greater keeps the lowest index on ties
function automatic int winning_state(pm_vec_t pm, int count);
    int best;

    best = 0;
    for (int n = 1; n < count; n++) begin
        if ($signed(pm[n]) > $signed(pm[best])) begin
            best = n;
        end
    end
    return best;
endfunction

// Active states taken relative to the winner while the rest carry over
function automatic pm_vec_t normalized_metrics(pm_vec_t pm, int count, int win, pm_vec_t prev);
    pm_vec_t nom;
    int      peak;

    nom  = prev;
    peak = int'($signed(pm[win]));
    for (int n = 0; n < count; n++) begin
        nom[n] = clamp_metric(int'($signed(pm[n])) - peak);
    end
    return nom;
endfunction

`endif

// ==== tb_pm_norm.sv ====
module tb_pm_norm
    import pm_trellis_pkg::*;
    import pm_metric_pkg::*;
();

    localparam logic [31:0] LFSR_SEED      = 32'h6c71;
    localparam int          RESET_CYCLES   = 16;
    localparam int          TIMEOUT_CYCLES = 20;

    typedef metric_t [NUM_STATES-1:0] pm_vec_t;

    logic         clk_i;
    logic         rst_an_i;
    logic         clear_i;
    logic         valid_i;
    search_mode_t mode_i;
    pm_vec_t      pm_i;
    logic         valid_o;
    pm_vec_t      pm_nom_o;
    state_idx_t   max_idx_o;

    logic [31:0]  lfsr_state;
    pm_vec_t      model_nom;

    // Items waiting to be driven and results waiting to be seen
    search_mode_t drv_mode_q [$];
    pm_vec_t      drv_pm_q [$];
    pm_vec_t      exp_nom_q [$];
    int           exp_idx_q [$];

    `include "tb_pm_norm_model.svh"

    pm_norm_top u_dut (
        .clk_i     (clk_i),
        .rst_an_i  (rst_an_i),
        .clear_i   (clear_i),
        .valid_i   (valid_i),
        .mode_i    (mode_i),
        .pm_i      (pm_i),
        .valid_o   (valid_o),
        .pm_nom_o  (pm_nom_o),
        .max_idx_o (max_idx_o)
    );

    bind pm_norm_top pm_norm_assertions u_assertions (
        .clk_i     (clk_i),
        .rst_an_i  (rst_an_i),
        .clear_i   (clear_i),
        .valid_i   (valid_i),
        .mode_i    (mode_i),
        .valid_o   (valid_o),
        .pm_nom_o  (pm_nom_o),
        .max_idx_o (max_idx_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    //--------------------------------------------------------------------------
    // Helpers
    //--------------------------------------------------------------------------

    task automatic abort_run(string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic next_lfsr_bit();
        logic fb;

        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] random_bits(int width);
        logic [31:0] value;

        value = '0;
        for (int b = 0; b < width; b++) begin
            value = {value[30:0], next_lfsr_bit()};
        end
        return value;
    endfunction

    function automatic pm_vec_t random_pm();
        pm_vec_t pm;

        for (int n = 0; n < NUM_STATES; n++) begin
            pm[n] = metric_t'(random_bits(8));
        end
        return pm;
    endfunction

    task automatic queue_item(search_mode_t mode, pm_vec_t pm);
        int count;
        int win;

        count     = mode_count(mode);
        win       = winning_state(pm, count);
        model_nom = normalized_metrics(pm, count, win, model_nom);
        drv_mode_q.push_back(mode);
        drv_pm_q.push_back(pm);
        exp_nom_q.push_back(model_nom);
        exp_idx_q.push_back(win);
    endtask

    task automatic compare_result();
        pm_vec_t exp_nom;
        int      exp_idx;

        exp_nom = exp_nom_q.pop_front();
        exp_idx = exp_idx_q.pop_front();
        check_val("max_idx_o", 32'(max_idx_o), 32'(exp_idx));
        for (int n = 0; n < NUM_STATES; n++) begin
            check_val($sformatf("pm_nom_o[%0d]", n), {24'h0, pm_nom_o[n]}, {24'h0, exp_nom[n]});
        end
        check_val("pm_nom_o[max_idx_o]", {24'h0, pm_nom_o[max_idx_o]}, 32'h0);
    endtask

    // Drives queued items back to back and checks each result as it leaves
    task automatic run_items();
        int waited;

        waited = 0;
        while (exp_idx_q.size() != 0) begin
            @(negedge clk_i);
            if (valid_o) begin
                compare_result();
                waited = 0;
            end else begin
                waited++;
                if (waited > TIMEOUT_CYCLES) begin
                    abort_run("timeout: valid_o never arrived for a queued item");
                end
            end
            if (drv_pm_q.size() != 0) begin
                valid_i = 1'b1;
                mode_i  = drv_mode_q.pop_front();
                pm_i    = drv_pm_q.pop_front();
            end else begin
                valid_i = 1'b0;
            end
        end
    endtask

    always @(negedge clk_i) begin
        if (u_dut.u_assertions.error_count != 0) begin
            abort_run("an assertion on the DUT failed");
        end
    end

    //--------------------------------------------------------------------------
    // Directed tests
    //--------------------------------------------------------------------------

    task automatic reset_outputs_zero();
        @(negedge clk_i);
        check_val("valid_o", 32'(valid_o), 32'h0);
        check_val("max_idx_o", 32'(max_idx_o), 32'h0);
        for (int n = 0; n < NUM_STATES; n++) begin
            check_val($sformatf("pm_nom_o[%0d]", n), {24'h0, pm_nom_o[n]}, 32'h0);
        end
    endtask

    task automatic full_search_random();
        for (int i = 0; i < 4; i++) begin
            queue_item(ALL_64, random_pm());
        end
        run_items();
    endtask

    task automatic saturation_and_ties();
        pm_vec_t pm;

        pm     = {NUM_STATES{METRIC_MIN}};
        pm[37] = METRIC_MAX;
        queue_item(ALL_64, pm);
        // Low background with a tie across groups 1 and 5
        for (int n = 0; n < NUM_STATES; n++) begin
            pm[n] = metric_t'(-128 + int'(random_bits(6)));
        end
        pm[12] = metric_t'(5);
        pm[45] = metric_t'(5);
        queue_item(ALL_64, pm);
        run_items();
        check_val("max_idx_o", 32'(max_idx_o), 32'd12);
    endtask

    task automatic partial_modes_hold();
        pm_vec_t      pm;
        search_mode_t modes [3];

        modes = '{LOW_8, LOW_16, LOW_32};
        queue_item(ALL_64, random_pm());
        foreach (modes[m]) begin
            pm = random_pm();
            for (int n = 0; n < NUM_STATES; n++) begin
                if (n >= mode_count(modes[m])) begin
                    pm[n] = METRIC_MAX;
                end else if (pm[n] == METRIC_MAX) begin
                    pm[n] = metric_t'(126);
                end
            end
            queue_item(modes[m], pm);
        end
        run_items();
    endtask

    task automatic stream_then_clear();
        for (int i = 0; i < 6; i++) begin
            queue_item(search_mode_t'(random_bits(2)), random_pm());
        end
        run_items();
        // Clear lands while two items are inside
        @(negedge clk_i);
        valid_i = 1'b1;
        mode_i  = ALL_64;
        pm_i    = random_pm();
        @(negedge clk_i);
        pm_i    = random_pm();
        clear_i = 1'b1;
        @(negedge clk_i);
        valid_i = 1'b0;
        clear_i = 1'b0;
        check_val("valid_o", 32'(valid_o), 32'h0);
        repeat (3) begin
            @(negedge clk_i);
            check_val("valid_o", 32'(valid_o), 32'h0);
        end
        check_val("max_idx_o", 32'(max_idx_o), 32'h0);
        for (int n = 0; n < NUM_STATES; n++) begin
            check_val($sformatf("pm_nom_o[%0d]", n), {24'h0, pm_nom_o[n]}, 32'h0);
        end
        model_nom = '0;
        queue_item(LOW_16, random_pm());
        run_items();
    endtask

    initial begin
        rst_an_i   = 1'b0;
        clear_i    = 1'b0;
        valid_i    = 1'b0;
        mode_i     = ALL_64;
        pm_i       = '0;
        model_nom  = '0;
        lfsr_state = LFSR_SEED;
        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        rst_an_i = 1'b1;

        reset_outputs_zero();
        full_search_random();
        saturation_and_ties();
        partial_modes_hold();
        stream_then_clear();

        @(negedge clk_i);
        if (u_dut.u_assertions.error_count != 0) begin
            abort_run("an assertion on the DUT failed");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule
